// File: design/net_tx_config.svh
// ------------------------------------------------
// network transmit constants
// ports, ttl, ethertypes, frame sizing and timing
// ------------------------------------------------
`ifndef NET_TX_CONFIG_SVH
`define NET_TX_CONFIG_SVH

// udp source port of this station
`define NET_LOCAL_PORT 16'd1024
// ipv4 time to live
`define NET_IP_TTL 8'd128
// ethertypes
`define NET_ETYPE_IP 16'h0800
`define NET_ETYPE_ARP 16'h0806
// dest mac through padding, fcs excluded
`define NET_MIN_FRAME 60
`define NET_PREAMBLE_LEN 7
`define NET_IFG_CYCLES 12
`define NET_ARP_LEN 28

`endif

// File: design/net_tx_pkg.sv
// ------------------------------------------------
// network transmit types
// addresses, lengths and request records
// ------------------------------------------------
package net_tx_pkg;

  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] port_t;
  typedef logic [15:0] len_t;
  typedef logic [31:0] fcs_t;

  // frame source currently owning the mac
  typedef enum logic {arp, udp} tx_proto_t;

  // this station
  typedef struct packed {
    mac_addr_t mac;
    ip_addr_t  ip;
  } local_addr_t;

  // station that gets the arp reply
  typedef struct packed {
    mac_addr_t target_mac;
    ip_addr_t  target_ip;
  } arp_req_t;

  // length is payload bytes only, 1..1400
  typedef struct packed {
    mac_addr_t dest_mac;
    ip_addr_t  dest_ip;
    port_t     dest_port;
    len_t      length;
  } udp_req_t;

  // per-frame info for the mac framer
  typedef struct packed {
    mac_addr_t   dest_mac;
    logic [15:0] ethertype;
    len_t        payload_len;
  } hdr_t;

endpackage

// File: design/tx_arbiter.sv
// ------------------------------------------------
// transmit arbiter
// arp before udp, one frame at a time, then gap
// ------------------------------------------------
`include "net_tx_config.svh"

module tx_arbiter (
  input  logic                  tx_clock,
  input  logic                  rst_n,
  input  logic                  arp_tx_request,
  input  logic                  udp_tx_request,
  input  net_tx_pkg::arp_req_t  arp_req,
  input  net_tx_pkg::udp_req_t  udp_req,
  input  logic                  frame_done,
  output logic                  arp_grant,
  output logic                  udp_grant,
  output net_tx_pkg::tx_proto_t proto,
  output net_tx_pkg::hdr_t      hdr,
  output logic                  start
);
  import net_tx_pkg::*;

  typedef enum logic [1:0] {s_idle, s_busy, s_gap} arb_state_t;

  arb_state_t state;
  logic [7:0] gap_cnt;
  logic       pick_arp;
  logic       pick_udp;

  // arp wins when both wait
  assign pick_arp = (state == s_idle) && arp_tx_request;
  assign pick_udp = (state == s_idle) && !arp_tx_request && udp_tx_request;

  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      state     <= s_idle;
      gap_cnt   <= '0;
      arp_grant <= 1'b0;
      udp_grant <= 1'b0;
      start     <= 1'b0;
      proto     <= arp;
    end else begin
      // grant and start are single-cycle pulses
      arp_grant <= pick_arp;
      udp_grant <= pick_udp;
      start     <= pick_arp || pick_udp;
      case (state)
        s_idle: begin
          if (pick_arp) begin
            proto <= arp;
            state <= s_busy;
          end else if (pick_udp) begin
            proto <= udp;
            state <= s_busy;
          end
        end
        s_busy: begin
          // frame_done arrives with the last fcs byte
          if (frame_done) begin
            gap_cnt <= 8'(`NET_IFG_CYCLES - 1);
            state   <= s_gap;
          end
        end
        s_gap: begin
          if (gap_cnt == '0) state <= s_idle;
          else gap_cnt <= gap_cnt - 8'd1;
        end
        default: state <= s_idle;
      endcase
    end
  end

  // ------------------------------------------------
  // frame header for mac_send, held until next grant
  // ------------------------------------------------
  always_ff @(posedge tx_clock) begin
    if (pick_arp) begin
      hdr.dest_mac    <= arp_req.target_mac;
      hdr.ethertype   <= `NET_ETYPE_ARP;
      hdr.payload_len <= len_t'(`NET_ARP_LEN);
    end else if (pick_udp) begin
      hdr.dest_mac    <= udp_req.dest_mac;
      hdr.ethertype   <= `NET_ETYPE_IP;
      // ip header 20 + udp header 8
      hdr.payload_len <= udp_req.length + 16'd28;
    end
  end

endmodule

// File: design/arp_reply_gen.sv
// ------------------------------------------------
// arp reply generator
// serves the 28-byte reply payload byte by byte
// ------------------------------------------------
`include "net_tx_config.svh"

module arp_reply_gen (
  input  logic                    tx_clock,
  input  logic                    rst_n,
  input  logic                    grant,
  input  net_tx_pkg::arp_req_t    arp_req,
  input  net_tx_pkg::local_addr_t local_addr,
  input  logic                    rd,
  output logic [7:0]              data
);
  import net_tx_pkg::*;

  arp_req_t   target;
  logic [4:0] cnt;
  logic [8*`NET_ARP_LEN-1:0] reply;

  // target captured at the grant
  always_ff @(posedge tx_clock) begin
    if (grant) target <= arp_req;
  end

  // byte pointer, parks on the last byte
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (grant) begin
      cnt <= '0;
    end else if (rd && (cnt != 5'(`NET_ARP_LEN - 1))) begin
      cnt <= cnt + 5'd1;
    end
  end

  // htype, ptype, hlen, plen, opcode reply
  // then sender pair, then target pair
  assign reply = {16'h0001, 16'h0800, 8'd6, 8'd4, 16'h0002,
                  local_addr.mac, local_addr.ip,
                  target.target_mac, target.target_ip};

  // first byte sits in the top of the vector
  assign data = reply[8 * (`NET_ARP_LEN - 1 - cnt) +: 8];

endmodule

// File: design/udp_send.sv
// ------------------------------------------------
// udp header insertion
// 8 header bytes then user payload on pull
// ------------------------------------------------
`include "net_tx_config.svh"

module udp_send (
  input  logic                 tx_clock,
  input  logic                 rst_n,
  input  logic                 grant,
  input  net_tx_pkg::udp_req_t udp_req,
  input  logic                 rd,
  input  logic [7:0]           user_data,
  output logic [7:0]           data,
  output logic                 user_rd
);
  import net_tx_pkg::*;

  port_t       dest_port;
  len_t        udp_len;
  len_t        cnt;
  logic        in_hdr;
  logic [63:0] udp_hdr;

  // ports and datagram length at the grant
  always_ff @(posedge tx_clock) begin
    if (grant) begin
      dest_port <= udp_req.dest_port;
      udp_len   <= udp_req.length + 16'd8;
    end
  end

  // bytes served so far in this datagram
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (grant) begin
      cnt <= '0;
    end else if (rd) begin
      cnt <= cnt + 16'd1;
    end
  end

  // checksum left at zero, allowed over ipv4
  assign udp_hdr = {`NET_LOCAL_PORT, dest_port, udp_len, 16'h0000};

  assign in_hdr = (cnt < 16'd8);

  // past the header every pull goes to the user
  assign data    = in_hdr ? udp_hdr[8 * (7 - cnt[2:0]) +: 8] : user_data;
  assign user_rd = rd && !in_hdr;

endmodule

// File: design/ip_send.sv
// ------------------------------------------------
// ipv4 header insertion
// 20 header bytes with checksum, then udp datagram
// ------------------------------------------------
`include "net_tx_config.svh"

module ip_send (
  input  logic                    tx_clock,
  input  logic                    rst_n,
  input  logic                    grant,
  input  net_tx_pkg::udp_req_t    udp_req,
  input  net_tx_pkg::local_addr_t local_addr,
  input  logic                    rd,
  input  logic [7:0]              udp_data,
  output logic [7:0]              data,
  output logic                    udp_rd
);
  import net_tx_pkg::*;

  ip_addr_t     dest_ip;
  len_t         tot_len;
  logic [15:0]  csum;
  logic [15:0]  ident;
  len_t         cnt;
  logic         in_hdr;
  len_t         tot_len_req;
  logic [19:0]  sum_raw;
  logic [16:0]  sum_fold;
  logic [15:0]  csum_calc;
  logic [159:0] ip_hdr;

  // ------------------------------------------------
  // header checksum, worked out from the request
  // ------------------------------------------------
  assign tot_len_req = udp_req.length + 16'd28;

  // checksum word itself counts as zero
  assign sum_raw = 20'h04500 + tot_len_req + ident + 20'h00000 +
                   {`NET_IP_TTL, 8'd17} +
                   local_addr.ip[31:16] + local_addr.ip[15:0] +
                   udp_req.dest_ip[31:16] + udp_req.dest_ip[15:0];

  // two folds of the end-around carry
  assign sum_fold  = sum_raw[15:0] + sum_raw[19:16];
  assign csum_calc = ~(sum_fold[15:0] + {15'h0, sum_fold[16]});

  always_ff @(posedge tx_clock) begin
    if (grant) begin
      dest_ip <= udp_req.dest_ip;
      tot_len <= tot_len_req;
      csum    <= csum_calc;
    end
  end

  // byte pointer and identification count
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      cnt   <= '0;
      ident <= '0;
    end else begin
      if (grant) cnt <= '0;
      else if (rd) cnt <= cnt + 16'd1;
      // bump once the last header byte leaves
      if (rd && (cnt == 16'd19)) ident <= ident + 16'd1;
    end
  end

  // flags/fragment zero, protocol 17 is udp
  assign ip_hdr = {8'h45, 8'h00, tot_len, ident, 16'h0000,
                   `NET_IP_TTL, 8'd17, csum,
                   local_addr.ip, dest_ip};

  assign in_hdr = (cnt < 16'd20);

  assign data   = in_hdr ? ip_hdr[8 * (19 - cnt[4:0]) +: 8] : udp_data;
  assign udp_rd = rd && !in_hdr;

endmodule

// File: design/mac_send.sv
// ------------------------------------------------
// ethernet mac framer
// preamble, sfd, header, payload, pad, crc-32 fcs
// ------------------------------------------------
`include "net_tx_config.svh"

module mac_send (
  input  logic                    tx_clock,
  input  logic                    rst_n,
  input  logic                    start,
  input  net_tx_pkg::hdr_t        hdr,
  input  net_tx_pkg::local_addr_t local_addr,
  input  logic [7:0]              payload,
  output logic                    payload_rd,
  output logic [7:0]              tx_data,
  output logic                    tx_en,
  output logic                    frame_done
);
  import net_tx_pkg::*;

  typedef enum logic [2:0] {
    p_idle, p_pre, p_sfd, p_hdr, p_pay, p_pad, p_fcs
  } phase_t;

  // phase and idx name the byte for the next edge
  phase_t       phase;
  len_t         idx;
  fcs_t         crc;
  len_t         pay_last;
  logic         in_body;
  logic [7:0]   nxt_byte;
  logic [111:0] eth_hdr;

  // reflected crc-32, one byte lsb first
  function automatic fcs_t crc_byte(input fcs_t c, input logic [7:0] d);
    fcs_t r;
    r = c ^ {24'h0, d};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ 32'hEDB88320) : (r >> 1);
    end
    return r;
  endfunction

  assign eth_hdr  = {hdr.dest_mac, local_addr.mac, hdr.ethertype};
  // body index of the last payload byte
  assign pay_last = 16'd13 + hdr.payload_len;
  assign in_body  = (phase == p_hdr) || (phase == p_pay) || (phase == p_pad);

  // source byte is consumed on the same edge
  assign payload_rd = (phase == p_pay);

  always_comb begin
    case (phase)
      p_sfd:   nxt_byte = 8'hD5;
      p_hdr:   nxt_byte = eth_hdr[8 * (13 - idx[3:0]) +: 8];
      p_pay:   nxt_byte = payload;
      p_pad:   nxt_byte = 8'h00;
      // inverted remainder, low byte first
      p_fcs:   nxt_byte = ~crc[8 * idx[1:0] +: 8];
      default: nxt_byte = 8'h55;
    endcase
  end

  // ------------------------------------------------
  // phase sequencing
  // ------------------------------------------------
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      phase      <= p_idle;
      idx        <= '0;
      tx_en      <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      idx        <= idx + 16'd1;
      case (phase)
        p_idle: begin
          // first preamble byte goes out with start
          tx_en <= start;
          idx   <= 16'd1;
          if (start) phase <= p_pre;
        end
        p_pre: begin
          if (idx == len_t'(`NET_PREAMBLE_LEN - 1)) phase <= p_sfd;
        end
        p_sfd: begin
          phase <= p_hdr;
          idx   <= '0;
        end
        p_hdr: begin
          if (idx == 16'd13) phase <= p_pay;
        end
        p_pay: begin
          if (idx == pay_last) begin
            if (idx < len_t'(`NET_MIN_FRAME - 1)) begin
              phase <= p_pad;
            end else begin
              phase <= p_fcs;
              idx   <= '0;
            end
          end
        end
        p_pad: begin
          if (idx == len_t'(`NET_MIN_FRAME - 1)) begin
            phase <= p_fcs;
            idx   <= '0;
          end
        end
        p_fcs: begin
          if (idx == 16'd3) begin
            phase      <= p_idle;
            frame_done <= 1'b1;
          end
        end
        default: phase <= p_idle;
      endcase
    end
  end

  // output byte and running crc over the body
  always_ff @(posedge tx_clock) begin
    tx_data <= nxt_byte;
    if (phase == p_sfd) crc <= '1;
    else if (in_body) crc <= crc_byte(crc, nxt_byte);
  end

endmodule

// File: design/net_tx_top.sv
// ------------------------------------------------
// network transmit top
// arbiter, arp and udp/ip sources, mac framer
// ------------------------------------------------
module net_tx_top (
  input  logic                    tx_clock,
  input  logic                    rst_n,
  input  net_tx_pkg::local_addr_t local_addr,
  input  logic                    arp_tx_request,
  input  net_tx_pkg::arp_req_t    arp_req,
  input  logic                    udp_tx_request,
  input  net_tx_pkg::udp_req_t    udp_req,
  input  logic [7:0]              udp_tx_data,
  output logic                    arp_tx_grant,
  output logic                    udp_tx_grant,
  output logic                    udp_data_rd,
  output logic [7:0]              tx_data,
  output logic                    tx_en
);
  import net_tx_pkg::*;

  tx_proto_t  proto;
  hdr_t       hdr;
  logic       start;
  logic       frame_done;
  logic       payload_rd;
  logic [7:0] payload;
  logic [7:0] arp_data;
  logic       arp_rd;
  logic [7:0] ip_data;
  logic       ip_rd;
  logic [7:0] udp_data;
  logic       udp_rd;

  tx_arbiter u_arb (
    .tx_clock       (tx_clock),
    .rst_n          (rst_n),
    .arp_tx_request (arp_tx_request),
    .udp_tx_request (udp_tx_request),
    .arp_req        (arp_req),
    .udp_req        (udp_req),
    .frame_done     (frame_done),
    .arp_grant      (arp_tx_grant),
    .udp_grant      (udp_tx_grant),
    .proto          (proto),
    .hdr            (hdr),
    .start          (start)
  );

  arp_reply_gen u_arp (
    .tx_clock   (tx_clock),
    .rst_n      (rst_n),
    .grant      (arp_tx_grant),
    .arp_req    (arp_req),
    .local_addr (local_addr),
    .rd         (arp_rd),
    .data       (arp_data)
  );

  // udp and ip stages both capture on the udp grant
  udp_send u_udp (
    .tx_clock  (tx_clock),
    .rst_n     (rst_n),
    .grant     (udp_tx_grant),
    .udp_req   (udp_req),
    .rd        (udp_rd),
    .user_data (udp_tx_data),
    .data      (udp_data),
    .user_rd   (udp_data_rd)
  );

  ip_send u_ip (
    .tx_clock   (tx_clock),
    .rst_n      (rst_n),
    .grant      (udp_tx_grant),
    .udp_req    (udp_req),
    .local_addr (local_addr),
    .rd         (ip_rd),
    .udp_data   (udp_data),
    .data       (ip_data),
    .udp_rd     (udp_rd)
  );

  // payload mux, pulls go only to the owner
  assign payload = (proto == arp) ? arp_data : ip_data;
  assign arp_rd  = payload_rd && (proto == arp);
  assign ip_rd   = payload_rd && (proto == udp);

  mac_send u_mac (
    .tx_clock   (tx_clock),
    .rst_n      (rst_n),
    .start      (start),
    .hdr        (hdr),
    .local_addr (local_addr),
    .payload    (payload),
    .payload_rd (payload_rd),
    .tx_data    (tx_data),
    .tx_en      (tx_en),
    .frame_done (frame_done)
  );

endmodule

// File: test/tb_clock.sv
// ------------------------------------------------
// testbench clock and reset
// period 8, reset held low for 8 cycles
// ------------------------------------------------
module tb_clock #(
  parameter int period       = 8,
  parameter int reset_cycles = 8
) (
  output logic tx_clock,
  output logic rst_n
);

  initial begin
    tx_clock = 1'b0;
    forever #(period / 2) tx_clock = ~tx_clock;
  end

  // release on a falling edge like every other input
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge tx_clock);
    @(negedge tx_clock);
    rst_n = 1'b1;
  end

endmodule

// File: test/tb_net_tx.sv
// ------------------------------------------------
// network transmit testbench
// case-file stimulus, frame capture and compare,
// grant order, gap and pull-count checks
// ------------------------------------------------
`include "net_tx_config.svh"

module tb_net_tx;
  import net_tx_pkg::*;

  localparam int        max_cases = 64;
  localparam int        buf_bytes = 2048;
  localparam mac_addr_t local_mac = 48'h02_00_5e_10_20_30;
  localparam ip_addr_t  local_ip  = 32'hc0a8_0a02;

  logic        tx_clock;
  logic        rst_n;
  local_addr_t local_addr;
  logic        arp_tx_request;
  arp_req_t    arp_req;
  logic        udp_tx_request;
  udp_req_t    udp_req;
  logic [7:0]  udp_tx_data;
  logic        arp_tx_grant;
  logic        udp_tx_grant;
  logic        udp_data_rd;
  logic [7:0]  tx_data;
  logic        tx_en;

  // cases as read from the data file
  logic       case_arp       [0:max_cases-1];
  mac_addr_t  case_mac       [0:max_cases-1];
  ip_addr_t   case_ip        [0:max_cases-1];
  port_t      case_port      [0:max_cases-1];
  len_t       case_len       [0:max_cases-1];
  logic [7:0] case_first     [0:max_cases-1];
  logic       case_pair      [0:max_cases-1];
  len_t       case_frame_len [0:max_cases-1];
  fcs_t       case_fcs       [0:max_cases-1];
  int         ncases;

  // driver to monitor hand-over
  int         arp_case;
  int         udp_case;
  logic [7:0] pending_first;
  int         arp_asks;
  int         udp_asks;

  // monitor state
  logic [7:0] frame [0:buf_bytes-1];
  int         nbytes;
  int         order_q [$];
  int         idle_cycles;
  int         frames_checked;
  int         udp_frames;
  int         arp_grants;
  int         udp_grants;
  int         rd_count;
  logic       rd_prev = 1'b0;
  logic [7:0] pay_next = 8'h00;

  int cycles;
  int cycle_limit = 1000000;

  int   i;
  int   wait_cycles;
  logic was_idle;
  logic both;

  tb_clock u_clock (
    .tx_clock (tx_clock),
    .rst_n    (rst_n)
  );

  net_tx_top u_dut (
    .tx_clock       (tx_clock),
    .rst_n          (rst_n),
    .local_addr     (local_addr),
    .arp_tx_request (arp_tx_request),
    .arp_req        (arp_req),
    .udp_tx_request (udp_tx_request),
    .udp_req        (udp_req),
    .udp_tx_data    (udp_tx_data),
    .arp_tx_grant   (arp_tx_grant),
    .udp_tx_grant   (udp_tx_grant),
    .udp_data_rd    (udp_data_rd),
    .tx_data        (tx_data),
    .tx_en          (tx_en)
  );

  // ------------------------------------------------
  // failure reporting and compare tasks
  // ------------------------------------------------
  task automatic report_mismatch(input string msg);
    $display("MISMATCH at time %0t: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("ERROR: %s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_mac(input mac_addr_t got, input mac_addr_t want, input string what);
    if (got !== want) report_mismatch($sformatf("%s got %h want %h", what, got, want));
  endtask

  task automatic check_ip(input ip_addr_t got, input ip_addr_t want, input string what);
    if (got !== want) report_mismatch($sformatf("%s got %h want %h", what, got, want));
  endtask

  task automatic check_len(input len_t got, input len_t want, input string what);
    if (got !== want) report_mismatch($sformatf("%s got %0d want %0d", what, got, want));
  endtask

  task automatic check_fcs(input fcs_t got, input fcs_t want, input string what);
    if (got !== want) report_mismatch($sformatf("%s got %h want %h", what, got, want));
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] want, input string what);
    if (got !== want) report_mismatch($sformatf("%s got %h want %h", what, got, want));
  endtask

  // big-endian 16-bit field, one byte at a time
  task automatic check_pair(input int o, input logic [15:0] want, input string what);
    check_byte(frame[o], want[15:8], {what, " high byte"});
    check_byte(frame[o+1], want[7:0], {what, " low byte"});
  endtask

  // ------------------------------------------------
  // reference models from the protocol rules
  // ------------------------------------------------
  function automatic mac_addr_t mac_at(input int o);
    return {frame[o], frame[o+1], frame[o+2], frame[o+3], frame[o+4], frame[o+5]};
  endfunction

  function automatic ip_addr_t ip_at(input int o);
    return {frame[o], frame[o+1], frame[o+2], frame[o+3]};
  endfunction

  function automatic len_t word_at(input int o);
    return {frame[o], frame[o+1]};
  endfunction

  // ten header words in wire order, checksum slot zero
  // end-around carry folded after every add
  function automatic logic [15:0] ip_checksum(input len_t total, input logic [15:0] ident,
                                              input ip_addr_t src, input ip_addr_t dst);
    logic [15:0] words [0:9];
    logic [16:0] acc;
    words[0] = {8'h45, 8'h00};
    words[1] = total;
    words[2] = ident;
    words[3] = 16'h0000;
    words[4] = {`NET_IP_TTL, 8'd17};
    words[5] = 16'h0000;
    words[6] = src[31:16];
    words[7] = src[15:0];
    words[8] = dst[31:16];
    words[9] = dst[15:0];
    acc = '0;
    for (int w = 0; w < 10; w++) begin
      acc = {1'b0, acc[15:0]} + {1'b0, words[w]};
      acc = {1'b0, acc[15:0]} + {16'h0, acc[16]};
    end
    return ~acc[15:0];
  endfunction

  // bit-serial crc-32, lsb of each byte first
  function automatic fcs_t crc32_over(input int first, input int last);
    fcs_t c;
    logic fb;
    c = 32'hFFFF_FFFF;
    for (int o = first; o <= last; o++) begin
      for (int b = 0; b < 8; b++) begin
        fb = c[0] ^ frame[o][b];
        c  = c >> 1;
        if (fb) c = c ^ 32'hEDB8_8320;
      end
    end
    return ~c;
  endfunction

  // ------------------------------------------------
  // frame checks
  // ------------------------------------------------
  task automatic check_arp_body(input int c);
    check_pair(22, 16'h0001, "arp hardware type");
    check_pair(24, 16'h0800, "arp protocol type");
    check_byte(frame[26], 8'd6, "arp hardware size");
    check_byte(frame[27], 8'd4, "arp protocol size");
    check_pair(28, 16'h0002, "arp opcode");
    check_mac(mac_at(30), local_mac, "arp sender mac");
    check_ip(ip_at(36), local_ip, "arp sender ip");
    check_mac(mac_at(40), case_mac[c], "arp target mac");
    check_ip(ip_at(46), case_ip[c], "arp target ip");
  endtask

  task automatic check_udp_body(input int c);
    len_t       total;
    logic [15:0] ident;
    logic [7:0]  want_b;
    total = case_len[c] + 16'd28;
    ident = 16'(udp_frames);
    check_byte(frame[22], 8'h45, "ip version/ihl");
    check_byte(frame[23], 8'h00, "ip tos");
    check_len(word_at(24), total, "ip total length");
    check_pair(26, ident, "ip identification");
    check_pair(28, 16'h0000, "ip flags/fragment");
    check_byte(frame[30], `NET_IP_TTL, "ip ttl");
    check_byte(frame[31], 8'd17, "ip protocol");
    check_pair(32, ip_checksum(total, ident, local_ip, case_ip[c]), "ip header checksum");
    check_ip(ip_at(34), local_ip, "ip source");
    check_ip(ip_at(38), case_ip[c], "ip destination");
    check_pair(42, 16'd1024, "udp source port");
    check_pair(44, case_port[c], "udp destination port");
    check_len(word_at(46), case_len[c] + 16'd8, "udp length");
    check_pair(48, 16'h0000, "udp checksum");
    // payload counts up from the first byte
    for (int k = 0; k < int'(case_len[c]); k++) begin
      want_b = case_first[c] + 8'(k);
      check_byte(frame[50 + k], want_b, $sformatf("udp payload byte %0d", k));
    end
  endtask

  task automatic check_frame(input int c);
    int   p;
    int   body;
    fcs_t got_fcs;
    p    = case_arp[c] ? 28 : int'(case_len[c]) + 28;
    body = (14 + p > 60) ? 14 + p : 60;
    check_len(len_t'(nbytes), len_t'(`NET_PREAMBLE_LEN + 1 + body + 4), "frame length rule");
    check_len(len_t'(nbytes), case_frame_len[c], "frame length from case file");
    for (int o = 0; o < `NET_PREAMBLE_LEN; o++) check_byte(frame[o], 8'h55, "preamble");
    check_byte(frame[7], 8'hD5, "sfd");
    check_mac(mac_at(8), case_mac[c], "destination mac");
    check_mac(mac_at(14), local_mac, "source mac");
    check_pair(20, case_arp[c] ? 16'h0806 : 16'h0800, "ethertype");
    if (case_arp[c]) check_arp_body(c);
    else check_udp_body(c);
    // zero fill up to the 60-byte minimum
    for (int o = 22 + p; o < 68; o++) check_byte(frame[o], 8'h00, "padding");
    got_fcs = {frame[nbytes-1], frame[nbytes-2], frame[nbytes-3], frame[nbytes-4]};
    check_fcs(got_fcs, crc32_over(8, nbytes - 5), "fcs by crc rule");
    if (case_fcs[c] != 32'h0) check_fcs(got_fcs, case_fcs[c], "fcs from case file");
    check_len(len_t'(rd_count), case_arp[c] ? 16'd0 : case_len[c], "udp_data_rd edges");
    rd_count = 0;
    if (!case_arp[c]) udp_frames++;
    frames_checked++;
  endtask

  // ------------------------------------------------
  // case file and request driving
  // ------------------------------------------------
  task automatic load_cases();
    int             fd;
    int             n;
    string          line;
    logic [63:0]    kind_s;
    logic [47:0]    mac_v;
    logic [31:0]    ip_v;
    logic [15:0]    port_v;
    int             len_v;
    logic [7:0]     first_v;
    int             pair_v;
    int             flen_v;
    logic [31:0]    fcs_v;
    fd = $fopen("test/net_tx_cases.txt", "r");
    if (fd == 0) abort_run("cannot open test/net_tx_cases.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %h %d %h %d %d %h", kind_s, mac_v, ip_v, port_v,
                    len_v, first_v, pair_v, flen_v, fcs_v);
        if (n == 9) begin
          if (ncases >= max_cases) abort_run("too many lines in the case file");
          if (kind_s != "arp" && kind_s != "udp") abort_run("unknown frame kind in case file");
          case_arp[ncases]       = (kind_s == "arp");
          case_mac[ncases]       = mac_v;
          case_ip[ncases]        = ip_v;
          case_port[ncases]      = port_v;
          case_len[ncases]       = len_t'(len_v);
          case_first[ncases]     = first_v;
          case_pair[ncases]      = (pair_v != 0);
          case_frame_len[ncases] = len_t'(flen_v);
          case_fcs[ncases]       = fcs_v;
          ncases++;
        end
      end
    end
    $fclose(fd);
    if (ncases == 0) abort_run("case file holds no cases");
  endtask

  task automatic post_request(input int c);
    if (case_arp[c]) begin
      arp_req.target_mac = case_mac[c];
      arp_req.target_ip  = case_ip[c];
      arp_tx_request     = 1'b1;
      arp_case           = c;
      arp_asks++;
    end else begin
      udp_req.dest_mac  = case_mac[c];
      udp_req.dest_ip   = case_ip[c];
      udp_req.dest_port = case_port[c];
      udp_req.length    = case_len[c];
      udp_tx_request    = 1'b1;
      udp_case          = c;
      pending_first     = case_first[c];
      udp_asks++;
    end
  endtask

  // hold requests until granted, arp must win a tie
  task automatic await_grants(input logic idle_start);
    int n;
    n = 0;
    while (arp_tx_request || udp_tx_request) begin
      @(negedge tx_clock);
      n++;
      if (idle_start && n == 1 && !(arp_tx_grant || udp_tx_grant))
        report_mismatch("no grant on the edge that sampled the request");
      if (idle_start && n == 1 && tx_en !== 1'b0)
        report_mismatch("tx_en high one edge after the request");
      if (idle_start && n == 2 && tx_en !== 1'b1)
        report_mismatch("tx_en not high two edges after the request");
      if (udp_tx_grant && arp_tx_request)
        report_mismatch("udp granted while an arp request waits");
      if (arp_tx_grant) arp_tx_request = 1'b0;
      if (udp_tx_grant) udp_tx_request = 1'b0;
    end
    if (idle_start && n == 1) begin
      @(negedge tx_clock);
      if (tx_en !== 1'b1) report_mismatch("tx_en not high two edges after the request");
    end
  endtask

  initial begin
    local_addr.mac = local_mac;
    local_addr.ip  = local_ip;
    arp_tx_request = 1'b0;
    arp_req        = '0;
    udp_tx_request = 1'b0;
    udp_req        = '0;
    udp_tx_data    = 8'h00;
    void'($urandom(32'h9f92_bd4b));
    load_cases();
    // frames plus gaps, four times over, plus slack
    cycle_limit = 0;
    for (int c = 0; c < ncases; c++) begin
      cycle_limit += int'(case_frame_len[c]) + `NET_IFG_CYCLES;
    end
    cycle_limit = 4 * cycle_limit + 2000;
    @(posedge rst_n);
    repeat (2) @(negedge tx_clock);
    i = 0;
    while (i < ncases) begin
      wait_cycles = int'($urandom % 21);
      repeat (wait_cycles) @(negedge tx_clock);
      @(negedge tx_clock);
      // well past the gap with nothing queued
      was_idle = (order_q.size() == 0) && (nbytes == 0) &&
                 (idle_cycles >= `NET_IFG_CYCLES + 2);
      both = case_pair[i] && (i + 1 < ncases) && (case_arp[i + 1] != case_arp[i]);
      post_request(i);
      if (both) post_request(i + 1);
      await_grants(was_idle);
      i = both ? i + 2 : i + 1;
    end
    while (frames_checked < ncases) @(negedge tx_clock);
    repeat (2 * `NET_IFG_CYCLES) @(negedge tx_clock);
    check_len(len_t'(arp_grants), len_t'(arp_asks), "arp grant pulses");
    check_len(len_t'(udp_grants), len_t'(udp_asks), "udp grant pulses");
    if (order_q.size() != 0 || nbytes != 0) begin
      abort_run("frame left unfinished after the last case");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

  // ------------------------------------------------
  // monitor, payload source and timeout
  // ------------------------------------------------
  always @(negedge tx_clock) begin
    // reset outputs, once the clock has ticked
    if (cycles > 0 && !rst_n && (tx_en !== 1'b0 || arp_tx_grant !== 1'b0 ||
                                 udp_tx_grant !== 1'b0 || udp_data_rd !== 1'b0))
      report_mismatch("outputs active during reset");
    // grant order is frame order
    if (arp_tx_grant) begin
      if (tx_en) abort_run("arp grant while a frame is on the wire");
      order_q.push_back(arp_case);
      arp_grants++;
    end
    if (udp_tx_grant) begin
      if (tx_en) abort_run("udp grant while a frame is on the wire");
      order_q.push_back(udp_case);
      udp_grants++;
      pay_next = pending_first;
      rd_prev  = 1'b0;
    end
    // byte consumed at the last rising edge
    if (rd_prev) pay_next = pay_next + 8'd1;
    rd_prev = udp_data_rd;
    if (udp_data_rd) rd_count++;
    udp_tx_data = pay_next;
    if (tx_en) begin
      if (nbytes == 0 && frames_checked > 0 && idle_cycles < `NET_IFG_CYCLES)
        report_mismatch($sformatf("only %0d idle cycles between frames", idle_cycles));
      if (nbytes >= buf_bytes) abort_run("frame longer than the capture buffer");
      frame[nbytes] = tx_data;
      nbytes++;
      idle_cycles = 0;
    end else begin
      if (nbytes > 0) begin
        if (order_q.size() == 0) abort_run("frame sent without a grant");
        check_frame(order_q.pop_front());
        nbytes = 0;
      end
      idle_cycles++;
    end
  end

  always @(posedge tx_clock) begin
    cycles++;
    if (cycles > cycle_limit) abort_run($sformatf("timeout after %0d cycles", cycles));
  end

endmodule

// File: test/net_tx_cases.txt
# kind dest_mac dest_ip dest_port(hex) length first_byte(hex) together frame_len fcs(hex)
# together=1 raises this request with the next line; fcs 0 means derive it by the crc rule
arp 0a1b2c3d4e5f c0a80a05 0000 0 00 0 72 00000000
udp 0a1b2c3d4e5f c0a80a05 1389 1 41 0 72 00000000
udp 3c970e112233 c0a80a06 0035 18 00 0 72 00000000
udp 3c970e112233 c0a80a06 0035 19 10 0 73 00000000
udp 001122334455 0a000001 d431 46 80 0 100 00000000
arp 001122334455 0a000001 0000 0 00 1 72 00000000
udp 001122334455 0a000001 d431 64 f0 0 118 00000000
udp a0b1c2d3e4f5 ac100001 ffff 100 c8 1 154 00000000
arp a0b1c2d3e4f5 ac100001 0000 0 00 0 72 00000000
udp ffffffffffff c0a80aff 2710 1400 00 0 1454 00000000
udp 0a1b2c3d4e5f c0a80a05 1389 255 fe 0 309 00000000
arp 5e0001020304 c0a80a63 0000 0 00 0 72 00000000
arp 5e0001020304 c0a80a64 0000 0 00 1 72 00000000
udp 5e0001020304 c0a80a64 0050 7 7f 0 72 00000000
udp 020000000001 c0a80a02 0001 300 33 0 354 00000000
udp 020000000001 c0a80a02 0001 512 01 0 566 00000000
arp 3c970e112233 c0a80a06 0000 0 00 0 72 00000000
udp 3c970e112233 c0a80a06 4000 33 aa 0 87 00000000
udp 0a1b2c3d4e5f c0a80a05 1389 2 00 0 72 00000000

// File: tb.f
+incdir+design
design/net_tx_pkg.sv
design/tx_arbiter.sv
design/arp_reply_gen.sv
design/udp_send.sv
design/ip_send.sv
design/mac_send.sv
design/net_tx_top.sv
test/tb_clock.sv
test/tb_net_tx.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_net_tx
FILELIST  := tb.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

# build and run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
